/* common/dcache_pkg.sv */
// widths are fixed at 32-bit words and 4-word lines, and only the set count scales
package dcache_pkg;

	// ----------------------------------------------------------
	// word and line geometry
	// ----------------------------------------------------------

	// processor data word
	localparam int WORD_W = 32;
	// memory transfer unit, one full line
	localparam int LINE_W = 128;
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;
	// word offset inside a line
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

	// ----------------------------------------------------------
	// address widths
	// ----------------------------------------------------------

	// processor side addresses words, byte offset already stripped
	localparam int ADDR_W = 30;
	// memory side addresses whole lines
	localparam int LINE_ADDR_W = ADDR_W - WORD_SEL_W;

	// set count used when the top level is not overridden
	localparam int DEFAULT_SETS = 4;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------

	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits in bits [31:0]
	typedef logic [LINE_W-1:0] line_t;

	// {tag, set, word}; set width comes from NUM_SETS in the users
	typedef logic [ADDR_W-1:0] word_addr_t;

	// word address minus the word offset
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// miss handling states
	typedef enum logic [1:0] {
		COMPARE_TAG = 2'b00,
		WRITE_BACK  = 2'b01,
		ALLOCATE    = 2'b10
	} cache_state_e;

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------

	// line holding a given word
	function automatic line_addr_t line_of(input word_addr_t addr);
		line_of = addr[ADDR_W-1:WORD_SEL_W];
	endfunction

endpackage

/* dcache/dcache_way.sv */
// NUM_SETS must be a power of two of at least 2, and at most one strobe is raised per cycle
`timescale 1ns/1ps

module dcache_way #(
	parameter int NUM_SETS = 4
) (
	input  logic                                              clk,
	input  logic                                              proc_reset,
	input  dcache_pkg::word_addr_t                            proc_addr,
	input  dcache_pkg::word_t                                 proc_wdata,
	input  dcache_pkg::line_t                                 mem_rdata,
	input  logic                                              fill,
	input  logic                                              word_write,
	input  logic                                              clean,
	output logic                                              hit,
	output logic                                              dirty,
	output logic [dcache_pkg::LINE_ADDR_W-$clog2(NUM_SETS)-1:0] victim_tag,
	output dcache_pkg::line_t                                 line,
	output dcache_pkg::word_t                                 word
);
	import dcache_pkg::*;

	localparam int SET_W = $clog2(NUM_SETS);
	localparam int TAG_W = LINE_ADDR_W - SET_W;

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------

	// status bits per set
	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;

	// tag and line payload
	logic [TAG_W-1:0] tag_q [NUM_SETS];
	line_t            data_q [NUM_SETS];

	// address fields
	logic [WORD_SEL_W-1:0] word_sel;
	logic [SET_W-1:0]      set_idx;
	logic [TAG_W-1:0]      req_tag;

	assign word_sel = proc_addr[WORD_SEL_W-1:0];
	assign set_idx  = proc_addr[WORD_SEL_W +: SET_W];
	assign req_tag  = proc_addr[ADDR_W-1 -: TAG_W];

	// ----------------------------------------------------------
	// lookup
	// ----------------------------------------------------------

	// an unfilled tag never matches since valid gates it
	assign hit = valid_q[set_idx] & (tag_q[set_idx] == req_tag);

	// dirty only counts on a valid line
	assign dirty = valid_q[set_idx] & dirty_q[set_idx];

	// victim view of the addressed set
	assign victim_tag = tag_q[set_idx];
	assign line       = data_q[set_idx];

	// word mux over the selected line
	always_comb begin
		word = line[WORD_W-1:0];
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (word_sel == w[WORD_SEL_W-1:0]) begin
				word = line[w*WORD_W +: WORD_W];
			end
		end
	end

	// ----------------------------------------------------------
	// updates
	// ----------------------------------------------------------

	// status bits
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (fill) begin
				// fresh line from memory is clean
				valid_q[set_idx] <= 1'b1;
				dirty_q[set_idx] <= 1'b0;
			end else if (word_write) begin
				dirty_q[set_idx] <= 1'b1;
			end else if (clean) begin
				// write-back finished
				dirty_q[set_idx] <= 1'b0;
			end
		end
	end

	// tag and data
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_q[set_idx]  <= req_tag;
			data_q[set_idx] <= mem_rdata;
		end else if (word_write) begin
			// only the addressed word changes
			data_q[set_idx][word_sel*WORD_W +: WORD_W] <= proc_wdata;
		end
	end

endmodule

/* dcache/dcache_ctrl.sv */
// two ways only, requests must be held through a stall and memory pulses mem_ready once each
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int NUM_SETS = 4
) (
	input  logic                                              clk,
	input  logic                                              proc_reset,
	input  logic                                              proc_read,
	input  logic                                              proc_write,
	input  dcache_pkg::word_addr_t                            proc_addr,
	input  logic                                              hit0,
	input  logic                                              hit1,
	input  logic                                              dirty0,
	input  logic                                              dirty1,
	input  logic [dcache_pkg::LINE_ADDR_W-$clog2(NUM_SETS)-1:0] victim_tag0,
	input  logic [dcache_pkg::LINE_ADDR_W-$clog2(NUM_SETS)-1:0] victim_tag1,
	input  dcache_pkg::line_t                                 line0,
	input  dcache_pkg::line_t                                 line1,
	input  dcache_pkg::word_t                                 word0,
	input  dcache_pkg::word_t                                 word1,
	input  logic                                              mem_ready,
	output dcache_pkg::word_t                                 proc_rdata,
	output logic                                              proc_stall,
	output logic                                              fill0,
	output logic                                              fill1,
	output logic                                              word_write0,
	output logic                                              word_write1,
	output logic                                              clean0,
	output logic                                              clean1,
	output logic                                              mem_read,
	output logic                                              mem_write,
	output dcache_pkg::line_addr_t                            mem_addr,
	output dcache_pkg::line_t                                 mem_wdata
);
	import dcache_pkg::*;

	localparam int SET_W = $clog2(NUM_SETS);
	localparam int TAG_W = LINE_ADDR_W - SET_W;

	// ----------------------------------------------------------
	// declarations
	// ----------------------------------------------------------

	cache_state_e state_q;
	cache_state_e state_d;

	// one bit per set where 0 picks way0 as next victim
	logic [NUM_SETS-1:0] repl_ptr_q;

	logic [SET_W-1:0] set_idx;

	// request and lookup summary
	logic req;
	logic any_hit;
	logic miss;

	// victim chosen by the pointer
	logic             vic_way;
	logic             vic_dirty;
	logic [TAG_W-1:0] vic_tag;
	line_t            vic_line;

	// state decodes
	logic in_compare;
	logic in_write_back;
	logic in_allocate;

	// handshake completions
	logic wb_done;
	logic alloc_done;

	// ----------------------------------------------------------
	// lookup combine
	// ----------------------------------------------------------

	assign set_idx = proc_addr[WORD_SEL_W +: SET_W];

	assign req     = proc_read | proc_write;
	assign any_hit = hit0 | hit1;
	assign miss    = req & ~any_hit;

	// victim selection stays stable while the request is held
	assign vic_way   = repl_ptr_q[set_idx];
	assign vic_dirty = vic_way ? dirty1 : dirty0;
	assign vic_tag   = vic_way ? victim_tag1 : victim_tag0;
	assign vic_line  = vic_way ? line1 : line0;

	// read data mux with way0 first
	always_comb begin
		if (hit0) begin
			proc_rdata = word0;
		end else if (hit1) begin
			proc_rdata = word1;
		end else begin
			proc_rdata = '0;
		end
	end

	// ----------------------------------------------------------
	// state machine
	// ----------------------------------------------------------

	assign in_compare    = (state_q == COMPARE_TAG);
	assign in_write_back = (state_q == WRITE_BACK);
	assign in_allocate   = (state_q == ALLOCATE);

	assign wb_done    = in_write_back & mem_ready;
	assign alloc_done = in_allocate & mem_ready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			COMPARE_TAG: begin
				// dirty victim goes out before the refill
				if (miss) begin
					state_d = vic_dirty ? WRITE_BACK : ALLOCATE;
				end
			end
			WRITE_BACK: begin
				if (mem_ready) begin
					state_d = ALLOCATE;
				end
			end
			ALLOCATE: begin
				// back to compare which then hits
				if (mem_ready) begin
					state_d = COMPARE_TAG;
				end
			end
			default: begin
				state_d = COMPARE_TAG;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= COMPARE_TAG;
		end else begin
			state_q <= state_d;
		end
	end

	// ----------------------------------------------------------
	// replacement pointers
	// ----------------------------------------------------------

	// flip on every fill so the other way goes next
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			repl_ptr_q <= '0;
		end else if (alloc_done) begin
			repl_ptr_q[set_idx] <= ~repl_ptr_q[set_idx];
		end
	end

	// ----------------------------------------------------------
	// processor side
	// ----------------------------------------------------------

	// stall on a miss and for the whole refill
	assign proc_stall = in_compare ? miss : 1'b1;

	// write hit lands on the completing edge
	assign word_write0 = in_compare & proc_write & hit0;
	assign word_write1 = in_compare & proc_write & hit1 & ~hit0;

	// ----------------------------------------------------------
	// memory side
	// ----------------------------------------------------------

	// read drops in the ready cycle
	assign mem_read  = in_allocate & ~mem_ready;
	// write held through the ready cycle
	assign mem_write = in_write_back;

	// victim line address during write-back and request line otherwise
	always_comb begin
		if (in_write_back) begin
			mem_addr = {vic_tag, set_idx};
		end else begin
			mem_addr = line_of(proc_addr);
		end
	end

	// sampled by memory only while mem_write is high
	assign mem_wdata = vic_line;

	// fill and clean go to the victim way
	assign fill0  = alloc_done & ~vic_way;
	assign fill1  = alloc_done & vic_way;
	assign clean0 = wb_done & ~vic_way;
	assign clean1 = wb_done & vic_way;

endmodule

/* verilog/dcache_top.sv */
// two-way write-back data cache with NUM_SETS a power of two of at least 2
`timescale 1ns/1ps

module dcache_top #(
	parameter int NUM_SETS = dcache_pkg::DEFAULT_SETS
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	// processor side
	input  logic                   proc_read,
	input  logic                   proc_write,
	input  dcache_pkg::word_addr_t proc_addr,
	input  dcache_pkg::word_t      proc_wdata,
	output dcache_pkg::word_t      proc_rdata,
	output logic                   proc_stall,
	// memory side
	output logic                   mem_read,
	output logic                   mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output dcache_pkg::line_t      mem_wdata,
	input  dcache_pkg::line_t      mem_rdata,
	input  logic                   mem_ready
);
	import dcache_pkg::*;

	localparam int TAG_W = LINE_ADDR_W - $clog2(NUM_SETS);

	// ----------------------------------------------------------
	// way results
	// ----------------------------------------------------------

	logic             hit0, hit1;
	logic             dirty0, dirty1;
	logic [TAG_W-1:0] victim_tag0, victim_tag1;
	line_t            line0, line1;
	word_t            word0, word1;

	// controller strobes
	logic fill0, fill1;
	logic word_write0, word_write1;
	logic clean0, clean1;

	// ----------------------------------------------------------
	// ways
	// ----------------------------------------------------------

	dcache_way #(.NUM_SETS(NUM_SETS)) way0 (
		.clk(clk), .proc_reset(proc_reset),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata), .mem_rdata(mem_rdata),
		.fill(fill0), .word_write(word_write0), .clean(clean0),
		.hit(hit0), .dirty(dirty0), .victim_tag(victim_tag0),
		.line(line0), .word(word0)
	);

	dcache_way #(.NUM_SETS(NUM_SETS)) way1 (
		.clk(clk), .proc_reset(proc_reset),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata), .mem_rdata(mem_rdata),
		.fill(fill1), .word_write(word_write1), .clean(clean1),
		.hit(hit1), .dirty(dirty1), .victim_tag(victim_tag1),
		.line(line1), .word(word1)
	);

	// ----------------------------------------------------------
	// controller
	// ----------------------------------------------------------

	dcache_ctrl #(.NUM_SETS(NUM_SETS)) ctrl (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write), .proc_addr(proc_addr),
		.hit0(hit0), .hit1(hit1), .dirty0(dirty0), .dirty1(dirty1),
		.victim_tag0(victim_tag0), .victim_tag1(victim_tag1),
		.line0(line0), .line1(line1), .word0(word0), .word1(word1),
		.mem_ready(mem_ready),
		.proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.fill0(fill0), .fill1(fill1),
		.word_write0(word_write0), .word_write1(word_write1),
		.clean0(clean0), .clean1(clean1),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule

/* test/dcache_properties.sv */
// bound into dcache_top and idle while proc_reset is high
`timescale 1ns/1ps

module dcache_properties (
	input logic clk,
	input logic proc_reset,
	input logic proc_stall,
	input logic mem_read,
	input logic mem_write,
	input logic mem_ready
);
	// running count of failed assertions
	int assert_failures = 0;

	// one memory direction at a time
	no_overlap: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
	else begin
		assert_failures = assert_failures + 1;
		$error("mem_read and mem_write high in the same cycle");
	end

	// any memory traffic means the processor is held
	stall_on_mem: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
	else begin
		assert_failures = assert_failures + 1;
		$error("memory request active while proc_stall is low");
	end

	// write-back always runs straight into the refill
	wb_then_fill: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_ready && mem_write) |=> mem_read)
	else begin
		assert_failures = assert_failures + 1;
		$error("mem_read not raised in the cycle after a finished write-back");
	end

endmodule

bind dcache_top dcache_properties props (
	.clk(clk), .proc_reset(proc_reset), .proc_stall(proc_stall),
	.mem_read(mem_read), .mem_write(mem_write), .mem_ready(mem_ready)
);

/* test/tb_dcache.sv */
// memory model covers line addresses 0 to 63 only and the driver keeps one request in flight
`timescale 1ns/1ps

module tb_dcache;
	import dcache_pkg::*;

	localparam int STALL_LIMIT = 200;
	localparam int RANDOM_OPS = 300;

	logic clk, proc_reset, proc_read, proc_write, proc_stall;
	word_addr_t proc_addr;
	word_t proc_wdata, proc_rdata;
	logic mem_read, mem_write, mem_ready;
	line_addr_t mem_addr;
	line_t mem_wdata, mem_rdata;

	// shadow copy of all 256 modeled words and the memory lines
	word_t shadow [256];
	line_t mem_lines [64];

	// memory model state
	logic [31:0] mem_rng, stim_rng;
	logic mem_busy, mem_is_write;
	logic [1:0] mem_delay;
	line_addr_t mem_req_addr, last_wb_addr;
	line_t mem_req_data;
	int read_reqs, write_backs, last_wait;
	logic run_aborted;
	int word_errors, line_errors, addr_errors, other_errors, assert_errors;

	dcache_top #(.NUM_SETS(4)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------------------------
	// helpers and reference model
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// power-on contents unique per word address
	function automatic word_t fill_word(input logic [7:0] a);
		return {8'hd0, a, ~a, a ^ 8'h3c};
	endfunction

	function automatic word_addr_t word_at(input int line, input int word);
		return word_addr_t'(line * WORDS_PER_LINE + word);
	endfunction

	// reference result for a read
	function automatic word_t expected_word(input word_addr_t addr);
		return shadow[addr[7:0]];
	endfunction

	function automatic line_t expected_line(input line_addr_t la);
		return {expected_word({la, 2'd3}), expected_word({la, 2'd2}),
			expected_word({la, 2'd1}), expected_word({la, 2'd0})};
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			word_errors++;
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			line_errors++;
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
		if (got !== exp) begin
			addr_errors++;
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		other_errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// one request held until proc_stall is low at a rising edge
	task automatic issue(input logic is_write, input word_addr_t addr, input word_t data);
		int waited;
		if (run_aborted) return;
		proc_read <= ~is_write;
		proc_write <= is_write;
		proc_addr <= addr;
		proc_wdata <= data;
		waited = 0;
		@(posedge clk);
		while (proc_stall && waited < STALL_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		last_wait = waited;
		if (proc_stall) begin
			note_failure($sformatf("request to %h still stalled after %0d cycles", addr, waited));
			run_aborted = 1'b1;
		end
	endtask

	// ----------------------------------------------------------
	// memory model and compare process
	// ----------------------------------------------------------

	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			mem_busy <= 1'b0;
		end else if (mem_ready) begin
			// single-cycle ready pulse
			mem_ready <= 1'b0;
		end else if (!mem_busy) begin
			if (mem_read || mem_write) begin
				mem_rng = xorshift32(mem_rng);
				mem_busy <= 1'b1;
				mem_delay <= mem_rng[1:0];
				mem_is_write <= mem_write;
				mem_req_addr <= mem_addr;
				mem_req_data <= mem_wdata;
				if (mem_read) read_reqs <= read_reqs + 1;
			end
		end else begin
			// request and write data must hold steady until ready
			if (mem_read === mem_is_write || mem_write !== mem_is_write
				|| mem_addr !== mem_req_addr
				|| (mem_is_write && mem_wdata !== mem_req_data)) begin
				note_failure("memory request changed before mem_ready");
			end
			if (mem_delay != 2'd0) begin
				mem_delay <= mem_delay - 2'd1;
			end else begin
				mem_busy <= 1'b0;
				mem_ready <= 1'b1;
				if (mem_req_addr[LINE_ADDR_W-1:6] != '0) begin
					note_failure("memory access outside the 64 modeled lines");
				end else if (mem_is_write) begin
					// victim must match the shadow at its own line address
					check_line("mem_wdata", mem_req_data, expected_line(mem_req_addr));
					mem_lines[mem_req_addr[5:0]] <= mem_req_data;
					write_backs <= write_backs + 1;
					last_wb_addr <= mem_req_addr;
				end else begin
					mem_rdata <= mem_lines[mem_req_addr[5:0]];
				end
			end
		end
	end

	// completed requests compare reads and track writes
	always @(posedge clk) begin
		if (!proc_reset && !proc_stall) begin
			if (proc_read) check_word("proc_rdata", proc_rdata, expected_word(proc_addr));
			if (proc_write) shadow[proc_addr[7:0]] = proc_wdata;
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------

	initial begin
		int reqs_before;
		int wbs_before;
		int rand_addr;
		logic is_write;
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		{mem_rng, stim_rng} = {32'h340a, 32'h340a};
		{read_reqs, write_backs, last_wait, run_aborted} = '0;
		{word_errors, line_errors, addr_errors, other_errors, assert_errors} = '0;
		for (logic [6:0] l = 7'd0; l < 7'd64; l++) begin
			for (logic [2:0] w = 3'd0; w < 3'd4; w++) begin
				shadow[{l[5:0], w[1:0]}] = fill_word({l[5:0], w[1:0]});
				mem_lines[l[5:0]][w[1:0]*WORD_W +: WORD_W] = fill_word({l[5:0], w[1:0]});
			end
		end
		repeat (16) @(posedge clk);
		proc_reset <= 1'b0;

		// cold reads each fetch their line
		reqs_before = read_reqs;
		issue(1'b0, word_at(0, 0), '0);
		issue(1'b0, word_at(1, 1), '0);
		if (!run_aborted && read_reqs != reqs_before + 2) note_failure("cold reads did not miss");

		// same line again hits without memory traffic
		reqs_before = read_reqs;
		issue(1'b0, word_at(0, 3), '0);
		if (!run_aborted && (read_reqs != reqs_before || last_wait != 0)) begin
			note_failure("repeated read of a cached line did not hit");
		end

		// write hit then the whole line read back
		issue(1'b1, word_at(0, 2), 32'hcafe_0002);
		if (!run_aborted && last_wait != 0) note_failure("write to a cached line stalled");
		for (int w = 0; w < WORDS_PER_LINE; w++) issue(1'b0, word_at(0, w), '0);

		// lines 2, 6 and 10 share set 2 so dirty line 2 gets evicted
		issue(1'b1, word_at(2, 1), 32'h1234_abcd);
		issue(1'b0, word_at(6, 0), '0);
		wbs_before = write_backs;
		issue(1'b0, word_at(10, 3), '0);
		if (!run_aborted) begin
			if (write_backs != wbs_before + 1) note_failure("dirty victim was not written back");
			check_addr("mem_addr", last_wb_addr, line_addr_t'(2));
		end
		issue(1'b0, word_at(2, 1), '0);

		// random mix over all modeled lines
		for (int i = 0; i < RANDOM_OPS && !run_aborted; i++) begin
			stim_rng = xorshift32(stim_rng);
			is_write = stim_rng[8];
			rand_addr = int'(stim_rng[7:0]);
			stim_rng = xorshift32(stim_rng);
			issue(is_write, word_addr_t'(rand_addr), stim_rng);
		end

		proc_read <= 1'b0;
		proc_write <= 1'b0;
		@(posedge clk);
		assert_errors = dut.props.assert_failures;
		$display("errors: read data %0d, write-back data %0d, write-back address %0d, %s",
			word_errors, line_errors, addr_errors,
			$sformatf("other %0d, assertions %0d", other_errors, assert_errors));
		if (word_errors + line_errors + addr_errors + other_errors + assert_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* sim.f */
common/dcache_pkg.sv
dcache/dcache_way.sv
dcache/dcache_ctrl.sv
verilog/dcache_top.sv
test/dcache_properties.sv
test/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_dcache \
	-f sim.f -o tb_dcache \
	&& ./obj_dir/tb_dcache +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
